/* dv/lsu_patterns.txt */
// cmd addr sdata rdata resp ack_dly resp_dly exc code ldata, all hex
// cmd as lsu_cmd_e, resp 1 ok 2 error, delays in cycles, ldata checked for good loads
3 00001000 00000000 deadbeef 1 0 0 0 0 deadbeef
3 00001004 00000000 12345678 1 2 1 0 0 12345678
2 00001002 00000000 00008001 1 0 0 0 0 ffff8001
2 00001000 00000000 ffff7ffe 1 1 2 0 0 00007ffe
5 00001006 00000000 1234abcd 1 0 1 0 0 0000abcd
5 0000100e 00000000 ffffffff 1 2 3 0 0 0000ffff
1 00001003 00000000 00000080 1 0 0 0 0 ffffff80
1 00001001 00000000 aaaa557f 1 1 0 0 0 0000007f
4 00001002 00000000 000000ff 1 0 2 0 0 000000ff
4 0000100b 00000000 12345680 1 3 0 0 0 00000080
6 00002001 000000a5 00000000 1 1 0 0 0 00000000
7 00002002 0000beef 00000000 1 0 2 0 0 00000000
8 00002004 cafef00d 00000000 1 3 1 0 0 00000000
2 00001001 00000000 00000000 0 0 0 1 4 00000000
5 00001003 00000000 00000000 0 0 0 1 4 00000000
3 00001002 00000000 00000000 0 0 0 1 4 00000000
3 00001001 00000000 00000000 0 0 0 1 4 00000000
7 00002003 00001234 00000000 0 0 0 1 6 00000000
8 00002002 89abcdef 00000000 0 0 0 1 6 00000000
8 00002007 01020304 00000000 0 0 0 1 6 00000000
3 00003000 00000000 5a5a5a5a 2 1 1 1 5 00000000
1 00003001 00000000 00000000 2 0 0 1 5 00000000
4 00003002 00000000 00000000 2 2 1 1 5 00000000
8 00003004 11112222 00000000 2 0 2 1 7 00000000
6 00003003 000000ff 00000000 2 1 0 1 7 00000000
7 00003006 0000abcd 00000000 2 0 0 1 7 00000000
3 00001ffc 00000000 0f0f0f0f 1 5 4 0 0 0f0f0f0f
2 00001004 00000000 00008000 1 2 2 0 0 ffff8000
1 00001000 00000000 12345601 1 0 3 0 0 00000001
3 00001ff8 00000000 80000000 1 1 1 0 0 80000000

/* sim.f */
+incdir+include
rtl/lsu_pkg.sv
rtl/lsu_access_check.sv
rtl/lsu_dmem_ctrl.sv
rtl/lsu_load_extend.sv
rtl/lsu_top.sv
dv/lsu_clk_gen.sv
dv/lsu_tb.sv

/* Makefile */
# Verilator build and run of the LSU testbench

VERILATOR  ?= verilator
TOP        ?= lsu_tb
LINT_TOP   ?= lsu_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert --timing
LINT_FLAGS ?= --lint-only --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv dv/*.sv include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

# Result decided from the log
run: $(SIM_BIN) dv/lsu_patterns.txt
	$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "No result line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb;

    import lsu_pkg::*;

    localparam int    FIELDS      = 10;  // Words per pattern line
    localparam int    MAX_PAT     = 64;
    localparam int    TIMEOUT_CYC = 50;
    localparam string PAT_FILE    = "dv/lsu_patterns.txt";

    logic                 clk;
    logic                 rst_n;
    logic                 exu_req_i;
    lsu_cmd_e             exu_cmd_i;
    logic [`LSU_XLEN-1:0] exu_addr_i;
    logic [`LSU_XLEN-1:0] exu_sdata_i;
    logic                 lsu_rdy_o;
    logic [`LSU_XLEN-1:0] lsu_ldata_o;
    logic                 lsu_exc_o;
    lsu_exc_code_e        lsu_exc_code_o;
    logic                 dmem_req_o;
    logic                 dmem_cmd_o;
    mem_width_e           dmem_width_o;
    logic [`LSU_XLEN-1:0] dmem_addr_o;
    logic [`LSU_XLEN-1:0] dmem_wdata_o;
    logic                 dmem_req_ack_i;
    logic [`LSU_XLEN-1:0] dmem_rdata_i;
    mem_resp_e            dmem_resp_i;

    logic [31:0] pat_mem [0:MAX_PAT*FIELDS-1];  // cmd addr sdata rdata resp ack rsp exc code ldata
    logic [31:0] lfsr;
    int          err_cnt;
    int          timeout_cnt;
    int          pat_cnt;

    lsu_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    lsu_top DUT (.*);

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic mem_width_e exp_width(input lsu_cmd_e cmd);
        case (cmd)
            LSU_CMD_LB, LSU_CMD_LBU, LSU_CMD_SB: return MEM_WIDTH_BYTE;
            LSU_CMD_LH, LSU_CMD_LHU, LSU_CMD_SH: return MEM_WIDTH_HWORD;
            default:                             return MEM_WIDTH_WORD;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s expected 0x%08h got 0x%08h (pattern %0d)",
                     name, exp, got, pat_cnt);
            err_cnt++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR: timed out waiting for %s in pattern %0d", what, pat_cnt);
        timeout_cnt++;
    endtask

    task automatic check_idle();
        check_val("dmem_req_o", 32'(dmem_req_o), 32'd0);
        check_val("lsu_rdy_o", 32'(lsu_rdy_o), 32'd0);
        check_val("lsu_exc_o", 32'(lsu_exc_o), 32'd0);
    endtask

    // Request fields must track the held EXU inputs
    task automatic check_request(input logic is_store);
        check_val("dmem_req_o", 32'(dmem_req_o), 32'd1);
        check_val("dmem_cmd_o", 32'(dmem_cmd_o), 32'(is_store ? MEM_CMD_WR : MEM_CMD_RD));
        check_val("dmem_width_o", 32'(dmem_width_o), 32'(exp_width(exu_cmd_i)));
        check_val("dmem_addr_o", dmem_addr_o, exu_addr_i);
        check_val("dmem_wdata_o", dmem_wdata_o, exu_sdata_i);
    endtask

    // ----------------------------------------
    // One pattern, EXU and DMEM side
    // ----------------------------------------

    task automatic run_pattern(input int base);
        logic is_store;
        logic mslgn;
        logic done;
        int   extra;
        int   ack_wait;
        int   resp_wait;
        int   cyc;
        mslgn = (pat_mem[base+8] == 32'(EXC_CODE_LD_MISALIGN))
              || (pat_mem[base+8] == 32'(EXC_CODE_ST_MISALIGN));
        draw_bits(2, extra);
        ack_wait = int'(pat_mem[base+5]) + extra;
        draw_bits(2, extra);
        resp_wait = int'(pat_mem[base+6]) + extra;

        @(posedge clk);
        #1;
        exu_req_i      = 1'b1;
        exu_cmd_i      = lsu_cmd_e'(pat_mem[base][3:0]);
        exu_addr_i     = pat_mem[base+1];
        exu_sdata_i    = pat_mem[base+2];
        dmem_req_ack_i = !mslgn && (ack_wait == 0);
        is_store       = exu_cmd_i inside {LSU_CMD_SB, LSU_CMD_SH, LSU_CMD_SW};

        // Request phase, ends on exception or on acceptance
        cyc  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (mslgn) begin
                check_val("dmem_req_o", 32'(dmem_req_o), 32'd0);  // Never sent
                done = lsu_exc_o;
            end else begin
                check_request(is_store);
                done = dmem_req_o & dmem_req_ack_i;
            end
            if (!done) begin
                cyc++;
                if (cyc > ack_wait + TIMEOUT_CYC) begin
                    report_timeout(mslgn ? "lsu_exc_o" : "request acceptance");
                    return;
                end
                @(posedge clk);
                #1;
                dmem_req_ack_i = !mslgn && (cyc >= ack_wait);
            end
        end

        if (mslgn) begin
            check_val("lsu_rdy_o", 32'(lsu_rdy_o), 32'd0);
        end else begin
            @(posedge clk);
            #1;
            dmem_req_ack_i = 1'b0;
            cyc  = 0;
            done = 1'b0;
            while (!done) begin
                if (cyc == resp_wait) begin
                    dmem_resp_i  = mem_resp_e'(pat_mem[base+4][1:0]);
                    dmem_rdata_i = pat_mem[base+3];
                end
                @(negedge clk);
                check_val("dmem_req_o", 32'(dmem_req_o), 32'd0);  // Busy
                if (cyc < resp_wait) begin
                    check_val("lsu_rdy_o", 32'(lsu_rdy_o), 32'd0);
                end else begin
                    done = lsu_rdy_o;
                end
                if (!done) begin
                    cyc++;
                    if (cyc > resp_wait + TIMEOUT_CYC) begin
                        report_timeout("lsu_rdy_o");
                        return;
                    end
                    @(posedge clk);
                    #1;
                end
            end
            if (!is_store && pat_mem[base+7] == 32'd0) begin
                check_val("lsu_ldata_o", lsu_ldata_o, pat_mem[base+9]);
            end
        end
        check_val("lsu_exc_o", 32'(lsu_exc_o), pat_mem[base+7]);
        check_val("lsu_exc_code_o", 32'(lsu_exc_code_o), pat_mem[base+8]);

        // EXU drops the request for a cycle
        @(posedge clk);
        #1;
        exu_req_i   = 1'b0;
        exu_cmd_i   = LSU_CMD_NONE;
        dmem_resp_i = MEM_RESP_NOTRDY;
        @(negedge clk);
        check_idle();
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        int i;
        int cyc;
        exu_req_i      = 1'b0;
        exu_cmd_i      = LSU_CMD_NONE;
        exu_addr_i     = '0;
        exu_sdata_i    = '0;
        dmem_req_ack_i = 1'b0;
        dmem_rdata_i   = '0;
        dmem_resp_i    = MEM_RESP_NOTRDY;
        lfsr           = 32'hbabf_1703;
        err_cnt        = 0;
        timeout_cnt    = 0;
        pat_cnt        = 0;

        // Unused slots read as end marker, cmd above 8
        for (i = 0; i < MAX_PAT*FIELDS; i++) begin
            pat_mem[i] = 32'hffff_0000 | 32'(i);
        end
        $readmemh(PAT_FILE, pat_mem);

        cyc = 0;
        while (rst_n !== 1'b1 && cyc <= TIMEOUT_CYC) begin
            @(posedge clk);
            cyc++;
        end
        if (rst_n !== 1'b1) begin
            report_timeout("reset release");
        end else begin
            repeat (3) begin
                @(negedge clk);
                check_idle();  // Quiet after reset
            end
            while (pat_cnt < MAX_PAT && pat_mem[pat_cnt*FIELDS] <= 32'd8
                   && timeout_cnt == 0) begin
                run_pattern(pat_cnt * FIELDS);
                pat_cnt++;
            end
            if (pat_cnt == 0) begin
                $display("ERROR: no patterns found in %s", PAT_FILE);
                err_cnt++;
            end
        end

        $display("Patterns %0d, check errors %0d, timeouts %0d", pat_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* dv/lsu_clk_gen.sv */
`timescale 1ns/1ps

module lsu_clk_gen #(
    parameter int HALF_PERIOD = 5,  // 10 ns clock
    parameter int RST_CYCLES  = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Reset released just after an edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

/* rtl/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top (
    input  logic                   clk,
    input  logic                   rst_n,

    // EXU side
    input  logic                   exu_req_i,
    input  lsu_pkg::lsu_cmd_e      exu_cmd_i,
    input  logic [`LSU_XLEN-1:0]   exu_addr_i,
    input  logic [`LSU_XLEN-1:0]   exu_sdata_i,
    output logic                   lsu_rdy_o,      // Response cycle
    output logic [`LSU_XLEN-1:0]   lsu_ldata_o,
    output logic                   lsu_exc_o,
    output lsu_pkg::lsu_exc_code_e lsu_exc_code_o,

    // DMEM side
    output logic                   dmem_req_o,
    output logic                   dmem_cmd_o,
    output lsu_pkg::mem_width_e    dmem_width_o,
    output logic [`LSU_XLEN-1:0]   dmem_addr_o,
    output logic [`LSU_XLEN-1:0]   dmem_wdata_o,
    input  logic                   dmem_req_ack_i,
    input  logic [`LSU_XLEN-1:0]   dmem_rdata_i,
    input  lsu_pkg::mem_resp_e     dmem_resp_i
);

    import lsu_pkg::*;

    logic          is_store;    // Decoded from live command
    mem_width_e    width;
    logic          mslgn_exc;
    lsu_exc_code_e mslgn_code;
    lsu_cmd_e      cmd_ff;      // Drives load extension

    // Address and store data go straight through
    assign dmem_addr_o  = exu_addr_i;
    assign dmem_wdata_o = exu_sdata_i;

    // ----------------------------------------
    // Submodules
    // ----------------------------------------

    lsu_access_check u_access_check (
        .exu_req_i      (exu_req_i),
        .exu_cmd_i      (exu_cmd_i),
        .exu_addr_low_i (exu_addr_i[1:0]),
        .is_load_o      (),            // Only used inside for the code
        .is_store_o     (is_store),
        .width_o        (width),
        .mslgn_exc_o    (mslgn_exc),
        .mslgn_code_o   (mslgn_code)
    );

    lsu_dmem_ctrl u_dmem_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .exu_req_i      (exu_req_i),
        .exu_cmd_i      (exu_cmd_i),
        .is_store_i     (is_store),
        .width_i        (width),
        .mslgn_exc_i    (mslgn_exc),
        .mslgn_code_i   (mslgn_code),
        .dmem_req_ack_i (dmem_req_ack_i),
        .dmem_resp_i    (dmem_resp_i),
        .dmem_req_o     (dmem_req_o),
        .dmem_cmd_o     (dmem_cmd_o),
        .dmem_width_o   (dmem_width_o),
        .cmd_ff_o       (cmd_ff),
        .lsu_rdy_o      (lsu_rdy_o),
        .lsu_exc_o      (lsu_exc_o),
        .lsu_exc_code_o (lsu_exc_code_o)
    );

    lsu_load_extend u_load_extend (
        .cmd_ff_i       (cmd_ff),
        .dmem_rdata_i   (dmem_rdata_i),
        .lsu_ldata_o    (lsu_ldata_o)
    );

endmodule

/* rtl/lsu_load_extend.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_load_extend (
    input  lsu_pkg::lsu_cmd_e     cmd_ff_i,      // Registered command
    input  logic [`LSU_XLEN-1:0]  dmem_rdata_i,  // Raw word from DMEM
    output logic [`LSU_XLEN-1:0]  lsu_ldata_o
);

    import lsu_pkg::*;

    lsu_data_u rdata;  // Byte / halfword views of read word
    logic [7:0]  rd_byte;
    logic [15:0] rd_hword;

    // ----------------------------------------
    // Field select
    // ----------------------------------------

    assign rdata    = dmem_rdata_i;
    assign rd_byte  = rdata.bytes[0];   // DMEM returns data in low lanes
    assign rd_hword = rdata.hwords[0];

    // ----------------------------------------
    // Extension
    // ----------------------------------------

    always_comb begin
        case (cmd_ff_i)
            LSU_CMD_LB:  lsu_ldata_o = {{(`LSU_XLEN-8){rd_byte[7]}}, rd_byte};
            LSU_CMD_LBU: lsu_ldata_o = {{(`LSU_XLEN-8){1'b0}}, rd_byte};
            LSU_CMD_LH:  lsu_ldata_o = {{(`LSU_XLEN-16){rd_hword[15]}}, rd_hword};
            LSU_CMD_LHU: lsu_ldata_o = {{(`LSU_XLEN-16){1'b0}}, rd_hword};
            default:     lsu_ldata_o = dmem_rdata_i;  // LW and stores, full word
        endcase
    end

endmodule

/* rtl/lsu_dmem_ctrl.sv */
`timescale 1ns/1ps

module lsu_dmem_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   exu_req_i,
    input  lsu_pkg::lsu_cmd_e      exu_cmd_i,
    input  logic                   is_store_i,      // Decoded store flag
    input  lsu_pkg::mem_width_e    width_i,
    input  logic                   mslgn_exc_i,
    input  lsu_pkg::lsu_exc_code_e mslgn_code_i,
    input  logic                   dmem_req_ack_i,  // DMEM took the request
    input  lsu_pkg::mem_resp_e     dmem_resp_i,
    output logic                   dmem_req_o,
    output logic                   dmem_cmd_o,      // 0 read, 1 write
    output lsu_pkg::mem_width_e    dmem_width_o,
    output lsu_pkg::lsu_cmd_e      cmd_ff_o,        // Command of access in flight
    output logic                   lsu_rdy_o,
    output logic                   lsu_exc_o,
    output lsu_pkg::lsu_exc_code_e lsu_exc_code_o
);

    import lsu_pkg::*;

    localparam logic FSM_IDLE = 1'b0;
    localparam logic FSM_BUSY = 1'b1;

    logic fsm_state;     // Idle/busy
    logic fsm_idle;
    logic req_accepted;  // Handshake done this cycle
    logic resp_ok;
    logic resp_er;
    logic resp_rcvd;     // Any final response while busy
    logic store_ff;      // In-flight access is a store

    // ----------------------------------------
    // Response decode
    // ----------------------------------------

    assign resp_ok   = (dmem_resp_i == MEM_RESP_RDY_OK);
    assign resp_er   = (dmem_resp_i == MEM_RESP_RDY_ER);
    assign resp_rcvd = ~fsm_idle & (resp_ok | resp_er);  // Ignore stray responses

    // ----------------------------------------
    // Idle/busy FSM
    // ----------------------------------------

    assign fsm_idle     = (fsm_state == FSM_IDLE);
    assign req_accepted = dmem_req_o & dmem_req_ack_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsm_state <= FSM_IDLE;
        end else if (fsm_idle) begin
            if (req_accepted) fsm_state <= FSM_BUSY;  // Busy from next cycle
        end else if (resp_rcvd) begin
            fsm_state <= FSM_IDLE;
        end
    end

    // Capture command with the handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_ff_o <= LSU_CMD_NONE;
            store_ff <= 1'b0;
        end else if (req_accepted) begin
            cmd_ff_o <= exu_cmd_i;
            store_ff <= is_store_i;
        end
    end

    // ----------------------------------------
    // DMEM request
    // ----------------------------------------

    // Held while ack is low, EXU keeps inputs stable
    assign dmem_req_o   = exu_req_i & fsm_idle & ~mslgn_exc_i;
    assign dmem_cmd_o   = is_store_i ? MEM_CMD_WR : MEM_CMD_RD;
    assign dmem_width_o = width_i;

    // ----------------------------------------
    // EXU response
    // ----------------------------------------

    assign lsu_rdy_o = resp_rcvd;
    assign lsu_exc_o = (resp_rcvd & resp_er) | mslgn_exc_i;

    // Access fault wins, misalign code is NONE otherwise
    always_comb begin
        if (resp_rcvd & resp_er) begin
            lsu_exc_code_o = store_ff ? EXC_CODE_ST_ACCESS_FAULT
                                      : EXC_CODE_LD_ACCESS_FAULT;
        end else begin
            lsu_exc_code_o = mslgn_code_i;
        end
    end

endmodule

/* rtl/lsu_access_check.sv */
`timescale 1ns/1ps

module lsu_access_check (
    input  logic                   exu_req_i,       // Access request from EXU
    input  lsu_pkg::lsu_cmd_e      exu_cmd_i,       // Raw command
    input  logic [1:0]             exu_addr_low_i,  // Address bits [1:0]
    output logic                   is_load_o,
    output logic                   is_store_o,
    output lsu_pkg::mem_width_e    width_o,         // Access size
    output logic                   mslgn_exc_o,     // Misaligned, request high
    output lsu_pkg::lsu_exc_code_e mslgn_code_o
);

    import lsu_pkg::*;

    logic addr_mslgn;  // Address not aligned to access size

    // ----------------------------------------
    // Command decode
    // ----------------------------------------

    always_comb begin
        is_load_o  = 1'b0;
        is_store_o = 1'b0;
        width_o    = MEM_WIDTH_WORD;  // Default for NONE, harmless
        case (exu_cmd_i)
            LSU_CMD_LB,
            LSU_CMD_LBU: begin
                is_load_o = 1'b1;
                width_o   = MEM_WIDTH_BYTE;
            end
            LSU_CMD_LH,
            LSU_CMD_LHU: begin
                is_load_o = 1'b1;
                width_o   = MEM_WIDTH_HWORD;
            end
            LSU_CMD_LW:  is_load_o = 1'b1;
            LSU_CMD_SB: begin
                is_store_o = 1'b1;
                width_o    = MEM_WIDTH_BYTE;
            end
            LSU_CMD_SH: begin
                is_store_o = 1'b1;
                width_o    = MEM_WIDTH_HWORD;
            end
            LSU_CMD_SW:  is_store_o = 1'b1;
            default: ;  // NONE, nothing to do
        endcase
    end

    // ----------------------------------------
    // Misalignment
    // ----------------------------------------

    // Bytes never misalign
    assign addr_mslgn  = ((width_o == MEM_WIDTH_HWORD) & exu_addr_low_i[0])
                       | ((width_o == MEM_WIDTH_WORD)  & (|exu_addr_low_i));
    assign mslgn_exc_o = exu_req_i & addr_mslgn & (is_load_o | is_store_o);

    always_comb begin
        if (!mslgn_exc_o)    mslgn_code_o = EXC_CODE_NONE;
        else if (is_store_o) mslgn_code_o = EXC_CODE_ST_MISALIGN;
        else                 mslgn_code_o = EXC_CODE_LD_MISALIGN;
    end

endmodule

/* rtl/lsu_pkg.sv */
`include "lsu_macros.svh"

package lsu_pkg;

    // ----------------------------------------
    // EXU side encodings
    // ----------------------------------------

    typedef enum logic [`LSU_CMD_W-1:0] {
        LSU_CMD_NONE = 4'd0,  // Idle / no access
        LSU_CMD_LB   = 4'd1,
        LSU_CMD_LH   = 4'd2,
        LSU_CMD_LW   = 4'd3,
        LSU_CMD_LBU  = 4'd4,
        LSU_CMD_LHU  = 4'd5,
        LSU_CMD_SB   = 4'd6,
        LSU_CMD_SH   = 4'd7,
        LSU_CMD_SW   = 4'd8
    } lsu_cmd_e;

    // Subset of mcause codes the LSU can raise
    typedef enum logic [`LSU_EXC_W-1:0] {
        EXC_CODE_NONE            = 4'd0,
        EXC_CODE_LD_MISALIGN     = 4'd4,
        EXC_CODE_LD_ACCESS_FAULT = 4'd5,
        EXC_CODE_ST_MISALIGN     = 4'd6,
        EXC_CODE_ST_ACCESS_FAULT = 4'd7
    } lsu_exc_code_e;

    // ----------------------------------------
    // DMEM side encodings
    // ----------------------------------------

    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'd0,  // No response this cycle
        MEM_RESP_RDY_OK = 2'd1,
        MEM_RESP_RDY_ER = 2'd2   // Bus error
    } mem_resp_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'd0,
        MEM_WIDTH_HWORD = 2'd1,
        MEM_WIDTH_WORD  = 2'd2
    } mem_width_e;

    localparam logic MEM_CMD_RD = 1'b0;  // Single bit memory command
    localparam logic MEM_CMD_WR = 1'b1;

    // Read word seen as bytes or as halfwords
    typedef union packed {
        logic [`LSU_XLEN/8-1:0][7:0]   bytes;
        logic [`LSU_XLEN/16-1:0][15:0] hwords;
    } lsu_data_u;

endpackage

/* include/lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------

// Address and data width, RV32
`define LSU_XLEN  32

// ----------------------------------------
// Encoded field widths
// ----------------------------------------

// LSU command field from EXU
`define LSU_CMD_W 4

// Exception code field back to EXU
`define LSU_EXC_W 4

`endif // LSU_MACROS_SVH
